// ==== src.f ====
+incdir+logic
logic/uart_pkg.sv
logic/baud_tick_gen.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_ctrl.sv
logic/uart_core.sv
testbench/uart_core_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
FLAGS      := --binary --timing
LINT_FLAGS := --lint-only --timing -Wall
TOP        := uart_core_tb
LINT_TOP   := uart_core
FILELIST   := src.f
OBJ_DIR    := obj_dir
BIN        := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '>>> PASS'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/uart_core_tb.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_core_tb;
	import uart_pkg::*;

	// One bit and one whole frame in system clocks
	localparam int bit_clks     = `UART_TICKS * `UART_CLK_DIV;
	localparam int frame_clks   = bit_clks * (`UART_DBIT + 2);
	localparam int timeout_clks = 4 * frame_clks;
	localparam int n_fixed      = 8;
	localparam int n_rows       = n_fixed + 4;

	typedef enum logic [1:0] {
		m_loopback,
		m_inject_good,
		m_inject_bad,
		m_back_to_back
	} mode_t;

	logic       clk;
	logic       reset;
	logic       send;
	logic       rx;
	uart_byte_t send_data;
	logic       tx;
	logic       tx_busy;
	logic       tx_drop;
	logic       tx_done;
	logic       rx_valid;
	rx_result_t rx_result;

	// rx is either the DUT's own tx or a frame bit-banged here
	logic loopback;
	logic rx_drv;

	// Stimulus table with one row per test
	string      t_name [n_rows];
	mode_t      t_mode [n_rows];
	uart_byte_t t_data [n_rows];
	logic       t_err  [n_rows];
	int         t_drop [n_rows];

	// Event counters kept by the monitor
	// Each row compares them against a snapshot taken when it starts
	int         rx_cnt;
	int         done_cnt;
	int         drop_cnt;
	int         busy_bad;
	rx_result_t rx_last;
	int         rx_base;
	int         done_base;
	int         drop_base;
	int         busy_base;

	logic        line_smp [frame_clks];
	logic [31:0] lcg_state;
	string       cur_name;
	string       first_msg;
	int          row_fails;
	int          n_pass;
	int          n_fail;

	assign rx = loopback ? tx : rx_drv;

	uart_core i_dut (
		.clk       (clk),
		.reset     (reset),
		.send      (send),
		.rx        (rx),
		.send_data (send_data),
		.tx        (tx),
		.tx_busy   (tx_busy),
		.tx_drop   (tx_drop),
		.tx_done   (tx_done),
		.rx_valid  (rx_valid),
		.rx_result (rx_result)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// The DUT registers all its strobes, so they are counted at the rising edge
	initial begin
		rx_cnt   = 0;
		done_cnt = 0;
		drop_cnt = 0;
		busy_bad = 0;
		rx_last  = '0;
	end

	always @(posedge clk) begin
		if (!reset) begin
			if (rx_valid) begin
				rx_cnt++;
				rx_last = rx_result;
			end
			if (tx_done) begin
				done_cnt++;
				// tx_busy has to drop in the same cycle as tx_done
				if (tx_busy) busy_bad++;
			end
			if (tx_drop) drop_cnt++;
		end
	end

	function automatic uart_byte_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	task automatic set_row(input int r, input string name, input mode_t mode,
			input uart_byte_t data, input logic err, input int drop);
		t_name[r] = name;
		t_mode[r] = mode;
		t_data[r] = data;
		t_err[r]  = err;
		t_drop[r] = drop;
	endtask

	task automatic load_table();
		int i;
		set_row(0, "loop_55", m_loopback, 8'h55, 1'b0, 0);
		set_row(1, "loop_a3", m_loopback, 8'ha3, 1'b0, 0);
		set_row(2, "loop_00", m_loopback, 8'h00, 1'b0, 0);
		set_row(3, "loop_ff", m_loopback, 8'hff, 1'b0, 0);
		set_row(4, "inj_good_3c", m_inject_good, 8'h3c, 1'b0, 0);
		set_row(5, "inj_bad_c5", m_inject_bad, 8'hc5, 1'b1, 0);
		// A good frame right after a bad one shows the receiver recovered
		set_row(6, "inj_good_81", m_inject_good, 8'h81, 1'b0, 0);
		set_row(7, "b2b_5a", m_back_to_back, 8'h5a, 1'b0, 1);
		for (i = 0; i < n_rows - n_fixed; i++) begin
			set_row(n_fixed + i, $sformatf("lcg_%0d", i), m_loopback, lcg_next(), 1'b0, 0);
		end
	endtask

	// Only the first failure of a row is kept for its closing line
	task automatic note_fail(input string msg);
		if (row_fails == 0) first_msg = msg;
		row_fails++;
	endtask

	task automatic start_row(input string name);
		cur_name  = name;
		row_fails = 0;
		first_msg = "";
		rx_base   = rx_cnt;
		done_base = done_cnt;
		drop_base = drop_cnt;
		busy_base = busy_bad;
	endtask

	task automatic finish_row();
		if (row_fails == 0) begin
			$display("ok     %s", cur_name);
			n_pass++;
		end else begin
			$display("%s", first_msg);
			n_fail++;
		end
	endtask

	task automatic send_byte(input uart_byte_t b);
		send      = 1'b1;
		send_data = b;
		@(negedge clk);
		send      = 1'b0;
	endtask

	task automatic wait_tx_fall(output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < timeout_clks; n++) begin
			@(negedge clk);
			if (!tx) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok) note_fail($sformatf("Timeout in %s: tx never left the idle level", cur_name));
	endtask

	// Waits for the receive strobe and, when a frame was sent, for tx_done
	task automatic wait_frame_end(input bit need_done);
		int n;
		for (n = 0; n < timeout_clks; n++) begin
			if (rx_cnt > rx_base && (done_cnt > done_base || !need_done)) break;
			@(negedge clk);
		end
		if (rx_cnt == rx_base) begin
			note_fail($sformatf("Timeout in %s: rx_valid never came", cur_name));
		end
		if (need_done && done_cnt == done_base) begin
			note_fail($sformatf("Timeout in %s: tx_done never came", cur_name));
		end
	endtask

	// Index 0 is the first clock of the start bit
	task automatic capture_line();
		int i;
		line_smp[0] = tx;
		for (i = 1; i < frame_clks; i++) begin
			@(negedge clk);
			line_smp[i] = tx;
		end
	endtask

	// Start bit low, data LSB first, stop bit high, each bit_clks long
	task automatic check_line(input uart_byte_t b);
		int   i;
		int   k;
		logic exp_bit;
		for (i = 0; i < frame_clks; i++) begin
			k = i / bit_clks;
			if (k == 0) exp_bit = 1'b0;
			else if (k <= `UART_DBIT) exp_bit = b[3'(k - 1)];
			else exp_bit = 1'b1;
			if (line_smp[i] !== exp_bit) begin
				note_fail($sformatf("Error: %s tx at clock %0d: expected %b, actual %b",
					cur_name, i, exp_bit, line_smp[i]));
			end
		end
	endtask

	task automatic run_send(input uart_byte_t b, input bit second);
		bit ok;
		loopback = 1'b1;
		send_byte(b);
		if (second) begin
			// The first send was taken, so tx_busy is already up here
			if (tx_busy !== 1'b1) begin
				note_fail($sformatf("Error: %s tx_busy after send: expected 1, actual %b",
					cur_name, tx_busy));
			end
			send_byte(~b);
		end
		wait_tx_fall(ok);
		if (ok) begin
			capture_line();
			check_line(b);
			wait_frame_end(1'b1);
			if (tx_busy !== 1'b0) begin
				note_fail($sformatf("Error: %s tx_busy after tx_done: expected 0, actual %b",
					cur_name, tx_busy));
			end
			if (busy_bad != busy_base) begin
				note_fail($sformatf("Error: %s tx_busy with tx_done: expected 0, actual 1",
					cur_name));
			end
		end
	endtask

	task automatic inject_frame(input uart_byte_t b, input logic stop_bit);
		int k;
		loopback = 1'b0;
		for (k = 0; k < `UART_DBIT + 2; k++) begin
			if (k == 0) rx_drv = 1'b0;
			else if (k <= `UART_DBIT) rx_drv = b[3'(k - 1)];
			else rx_drv = stop_bit;
			repeat (bit_clks) @(negedge clk);
		end
		rx_drv = 1'b1;
		wait_frame_end(1'b0);
	endtask

	task automatic run_row(input int r);
		// Idle gap with the line high so the receiver is back in idle
		loopback = 1'b1;
		rx_drv   = 1'b1;
		repeat (2 * bit_clks) @(negedge clk);
		start_row(t_name[r]);
		case (t_mode[r])
			m_loopback:     run_send(t_data[r], 1'b0);
			m_back_to_back: run_send(t_data[r], 1'b1);
			m_inject_good:  inject_frame(t_data[r], 1'b1);
			default:        inject_frame(t_data[r], 1'b0);
		endcase
		if (t_mode[r] == m_back_to_back) begin
			// The dropped byte must never reach the line
			repeat (frame_clks) @(negedge clk);
			if (rx_cnt - rx_base != 1) begin
				note_fail($sformatf("Error: %s rx_valid count: expected 1, actual %0d",
					cur_name, rx_cnt - rx_base));
			end
		end
		if (rx_cnt > rx_base && rx_last.data !== t_data[r]) begin
			note_fail($sformatf("Error: %s rx data: expected %h, actual %h",
				cur_name, t_data[r], rx_last.data));
		end
		if (rx_cnt > rx_base && rx_last.frame_err !== t_err[r]) begin
			note_fail($sformatf("Error: %s frame_err: expected %b, actual %b",
				cur_name, t_err[r], rx_last.frame_err));
		end
		if (drop_cnt - drop_base != t_drop[r]) begin
			note_fail($sformatf("Error: %s tx_drop count: expected %0d, actual %0d",
				cur_name, t_drop[r], drop_cnt - drop_base));
		end
		finish_row();
	endtask

	task automatic check_reset_values();
		int i;
		start_row("reset_values");
		for (i = 0; i < 8; i++) begin
			@(negedge clk);
			if (tx !== 1'b1) begin
				note_fail($sformatf("Error: %s tx: expected 1, actual %b", cur_name, tx));
			end
			if ({tx_busy, tx_drop, tx_done, rx_valid} !== 4'b0000) begin
				note_fail($sformatf("Error: %s busy/drop/done/valid: expected 0000, actual %b",
					cur_name, {tx_busy, tx_drop, tx_done, rx_valid}));
			end
			if (rx_result !== '0) begin
				note_fail($sformatf("Error: %s rx_result: expected 0, actual %h",
					cur_name, rx_result));
			end
		end
		finish_row();
	endtask

	initial begin
		int r;
		reset     = 1'b1;
		send      = 1'b0;
		send_data = '0;
		rx_drv    = 1'b1;
		loopback  = 1'b1;
		n_pass    = 0;
		n_fail    = 0;
		lcg_state = 32'd64718;
		load_table();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_reset_values();
		for (r = 0; r < n_rows; r++) begin
			run_row(r);
		end
		$display("%0d tests run, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== logic/uart_core.sv ====
`timescale 1ns/1ps

module uart_core (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 send,
	input  logic                 rx,
	input  uart_pkg::uart_byte_t send_data,
	output logic                 tx,
	output logic                 tx_busy,
	output logic                 tx_drop,
	output logic                 tx_done,
	output logic                 rx_valid,
	output uart_pkg::rx_result_t rx_result
);
	import uart_pkg::*;

	// Oversampling time base shared by both serial blocks
	logic       tick;

	// Transmit path between control and transmitter
	logic       tx_go;
	logic       tx_done_tick;
	tx_req_t    tx_req;

	// Receive path between receiver and control
	logic       rx_done_tick;
	rx_result_t rx_frame;

	baud_tick_gen i_baud_tick_gen (
		.clk   (clk),
		.reset (reset),
		.tick  (tick)
	);

	uart_tx i_uart_tx (
		.clk          (clk),
		.reset        (reset),
		.tick         (tick),
		.tx_go        (tx_go),
		.tx_req       (tx_req),
		.tx_done_tick (tx_done_tick),
		.tx           (tx)
	);

	uart_rx i_uart_rx (
		.clk          (clk),
		.reset        (reset),
		.tick         (tick),
		.rx           (rx),
		.rx_done_tick (rx_done_tick),
		.rx_frame     (rx_frame)
	);

	// Sits between the outside strobes and both serial blocks
	uart_ctrl i_uart_ctrl (
		.clk          (clk),
		.reset        (reset),
		.send         (send),
		.tx_done_tick (tx_done_tick),
		.rx_done_tick (rx_done_tick),
		.send_data    (send_data),
		.rx_frame     (rx_frame),
		.tx_go        (tx_go),
		.tx_busy      (tx_busy),
		.tx_drop      (tx_drop),
		.tx_done      (tx_done),
		.rx_valid     (rx_valid),
		.tx_req       (tx_req),
		.rx_result    (rx_result)
	);

endmodule

// ==== logic/uart_ctrl.sv ====
`timescale 1ns/1ps

module uart_ctrl (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 send,
	input  logic                 tx_done_tick,
	input  logic                 rx_done_tick,
	input  uart_pkg::uart_byte_t send_data,
	input  uart_pkg::rx_result_t rx_frame,
	output logic                 tx_go,
	output logic                 tx_busy,
	output logic                 tx_drop,
	output logic                 tx_done,
	output logic                 rx_valid,
	output uart_pkg::tx_req_t    tx_req,
	output uart_pkg::rx_result_t rx_result
);

	logic accept;

	// A send is taken only while no frame is going out
	assign accept = send & ~tx_busy;

	// Busy flag and the outgoing strobes
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tx_busy <= 1'b0;
			tx_go   <= 1'b0;
			tx_drop <= 1'b0;
			tx_done <= 1'b0;
		end else begin
			// Set on acceptance, cleared when the stop bit has gone out
			if (accept) begin
				tx_busy <= 1'b1;
			end else if (tx_done_tick) begin
				tx_busy <= 1'b0;
			end
			tx_go   <= accept;
			// A request during a frame is lost and reported one clock later
			tx_drop <= send & tx_busy;
			// Lines up with the falling edge of tx_busy
			tx_done <= tx_done_tick;
		end
	end

	// Request payload is captured together with tx_go
	always_ff @(posedge clk) begin
		if (accept) begin
			tx_req.data <= send_data;
		end
	end

	// Receive result and its valid strobe, one clock behind the receiver
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_valid  <= 1'b0;
			rx_result <= '0;
		end else begin
			rx_valid <= rx_done_tick;
			if (rx_done_tick) begin
				rx_result <= rx_frame;
			end
		end
	end

endmodule

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_rx (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 tick,
	input  logic                 rx,
	output logic                 rx_done_tick,
	output uart_pkg::rx_result_t rx_frame
);
	import uart_pkg::*;

	// Half a bit minus one tick puts the first sample in the middle of the start bit
	localparam tick_cnt_t half_tick = tick_cnt_t'(`UART_TICKS / 2 - 1);
	localparam tick_cnt_t last_tick = tick_cnt_t'(`UART_TICKS - 1);
	localparam bit_cnt_t  last_bit  = bit_cnt_t'(`UART_DBIT - 1);

	logic       rx_meta, rx_sync, rx_prev;
	logic       fall;
	rx_state_t  state_reg, state_next;
	tick_cnt_t  tick_reg, tick_next;
	bit_cnt_t   bit_reg, bit_next;
	uart_byte_t shift_reg, shift_next;
	logic       err_reg, err_next;
	logic       done_reg, done_next;

	// Two-flop synchronizer plus one more stage for edge detection
	// All stages reset high, matching an idle line
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// A frame can only start on a high-to-low transition of the line
	// After a bad stop bit the line has to return high first
	assign fall = rx_prev & ~rx_sync;

	// FSM control registers
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_reg <= rx_idle;
			tick_reg  <= '0;
			bit_reg   <= '0;
			done_reg  <= 1'b0;
		end else begin
			state_reg <= state_next;
			tick_reg  <= tick_next;
			bit_reg   <= bit_next;
			done_reg  <= done_next;
		end
	end

	// Received data and the stop-bit flag
	always_ff @(posedge clk) begin
		shift_reg <= shift_next;
		err_reg   <= err_next;
	end

	always_comb begin
		state_next = state_reg;
		tick_next  = tick_reg;
		bit_next   = bit_reg;
		shift_next = shift_reg;
		err_next   = err_reg;
		done_next  = 1'b0;

		case (state_reg)
			rx_idle: begin
				if (fall) begin
					state_next = rx_start;
					tick_next  = '0;
				end
			end

			rx_start: begin
				if (tick) begin
					if (tick_reg == half_tick) begin
						// Middle of the start bit, a high line here was a glitch
						if (!rx_sync) begin
							state_next = rx_data;
							tick_next  = '0;
							bit_next   = '0;
						end else begin
							state_next = rx_idle;
						end
					end else begin
						tick_next = tick_reg + 1'b1;
					end
				end
			end

			rx_data: begin
				if (tick) begin
					if (tick_reg == last_tick) begin
						// One full bit later we are in the middle of the next bit
						tick_next  = '0;
						shift_next = {rx_sync, shift_reg[`UART_DBIT-1:1]};
						if (bit_reg == last_bit) begin
							state_next = rx_stop;
						end else begin
							bit_next = bit_reg + 1'b1;
						end
					end else begin
						tick_next = tick_reg + 1'b1;
					end
				end
			end

			rx_stop: begin
				if (tick) begin
					if (tick_reg == last_tick) begin
						// Middle of the stop bit, a low line is a framing error
						state_next = rx_idle;
						tick_next  = '0;
						err_next   = ~rx_sync;
						done_next  = 1'b1;
					end else begin
						tick_next = tick_reg + 1'b1;
					end
				end
			end

			default: begin
				state_next = rx_idle;
			end
		endcase
	end

	// The frame is stable while the done strobe is high
	assign rx_done_tick = done_reg;
	assign rx_frame     = '{data: shift_reg, frame_err: err_reg};

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module uart_tx (
	input  logic              clk,
	input  logic              reset,
	input  logic              tick,
	input  logic              tx_go,
	input  uart_pkg::tx_req_t tx_req,
	output logic              tx_done_tick,
	output logic              tx
);
	import uart_pkg::*;

	// Last tick of a bit period and index of the last data bit
	localparam tick_cnt_t last_tick = tick_cnt_t'(`UART_TICKS - 1);
	localparam bit_cnt_t  last_bit  = bit_cnt_t'(`UART_DBIT - 1);

	tx_state_t  state_reg, state_next;
	tick_cnt_t  tick_reg, tick_next;
	bit_cnt_t   bit_reg, bit_next;
	uart_byte_t shift_reg, shift_next;
	logic       tx_reg, tx_next;

	// Control registers, the line idles high out of reset
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_reg <= tx_idle;
			tick_reg  <= '0;
			bit_reg   <= '0;
			tx_reg    <= 1'b1;
		end else begin
			state_reg <= state_next;
			tick_reg  <= tick_next;
			bit_reg   <= bit_next;
			tx_reg    <= tx_next;
		end
	end

	// Data shift register
	always_ff @(posedge clk) begin
		shift_reg <= shift_next;
	end

	// Next-state logic
	// Every change of the line happens on a tick edge, so each bit is exactly
	// UART_TICKS ticks wide no matter when tx_go arrived
	always_comb begin
		state_next   = state_reg;
		tick_next    = tick_reg;
		bit_next     = bit_reg;
		shift_next   = shift_reg;
		tx_next      = tx_reg;
		tx_done_tick = 1'b0;

		case (state_reg)
			tx_idle: begin
				tx_next = 1'b1;
				// The control block only strobes tx_go when we are free
				if (tx_go) begin
					state_next = tx_start;
					tick_next  = '0;
					shift_next = tx_req.data;
				end
			end

			tx_start: begin
				if (tick) begin
					if (tx_reg) begin
						// First tick after the request, the start bit begins here
						tx_next = 1'b0;
					end else if (tick_reg == last_tick) begin
						state_next = tx_data;
						tick_next  = '0;
						bit_next   = '0;
						tx_next    = shift_reg[0];
					end else begin
						tick_next = tick_reg + 1'b1;
					end
				end
			end

			tx_data: begin
				if (tick) begin
					if (tick_reg == last_tick) begin
						tick_next  = '0;
						shift_next = shift_reg >> 1;
						if (bit_reg == last_bit) begin
							// All data bits are out, drive the stop bit
							state_next = tx_stop;
							tx_next    = 1'b1;
						end else begin
							bit_next = bit_reg + 1'b1;
							// Next bit sits in position one before the shift
							tx_next  = shift_reg[1];
						end
					end else begin
						tick_next = tick_reg + 1'b1;
					end
				end
			end

			tx_stop: begin
				tx_next = 1'b1;
				if (tick) begin
					if (tick_reg == last_tick) begin
						// Full stop bit done, report the end of the frame
						state_next   = tx_idle;
						tick_next    = '0;
						tx_done_tick = 1'b1;
					end else begin
						tick_next = tick_reg + 1'b1;
					end
				end
			end

			default: begin
				state_next = tx_idle;
			end
		endcase
	end

	assign tx = tx_reg;

endmodule

// ==== logic/baud_tick_gen.sv ====
`timescale 1ns/1ps
`include "uart_params.svh"

module baud_tick_gen (
	input  logic clk,
	input  logic reset,
	output logic tick
);

	// Counter width, kept at one bit when the divisor is one
	localparam int cnt_w = (`UART_CLK_DIV > 1) ? $clog2(`UART_CLK_DIV) : 1;

	// Value at which the counter wraps back to zero
	localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`UART_CLK_DIV - 1);

	logic [cnt_w-1:0] cnt_reg;

	// Free-running divider shared by the transmitter and the receiver
	// The tick is registered so it is a clean one-clock pulse
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cnt_reg <= '0;
			tick    <= 1'b0;
		end else begin
			if (cnt_reg == last_cnt) begin
				cnt_reg <= '0;
			end else begin
				cnt_reg <= cnt_reg + 1'b1;
			end
			// One pulse per wrap, so one every UART_CLK_DIV clocks
			tick <= (cnt_reg == last_cnt);
		end
	end

endmodule

// ==== logic/uart_pkg.sv ====
package uart_pkg;

	// One data word as it travels on the serial line
	typedef logic [7:0] uart_byte_t;

	// Position inside one bit period, counted in oversampling ticks
	typedef logic [3:0] tick_cnt_t;

	// Index of the data bit currently on the line
	typedef logic [2:0] bit_cnt_t;

	// Send request handed from the control block to the transmitter
	typedef struct packed {
		uart_byte_t data;
	} tx_req_t;

	// Received word together with its stop-bit check
	// frame_err is set when the stop bit was sampled low
	typedef struct packed {
		uart_byte_t data;
		logic       frame_err;
	} rx_result_t;

	// Transmitter FSM
	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_data,
		tx_stop
	} tx_state_t;

	// Receiver FSM
	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

endpackage

// ==== logic/uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// Frame format and timing of the serial core
// One frame is a start bit, UART_DBIT data bits and a single stop bit

// Data bits in one frame, sent and received LSB first
`define UART_DBIT 8

// Oversampling ticks that make up one bit period
// The receiver samples at tick UART_TICKS/2 of the start bit
`define UART_TICKS 16

// System clocks between two oversampling ticks
// With the values here a bit lasts 64 clocks and a frame 640 clocks
`define UART_CLK_DIV 4

`endif
